// File: source/audio_settings.svh
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// Audio sample width, signed two's complement
`define AUDIO_SAMPLE_W 16

// Wishbone classic register bus
`define WB_ADR_W 2
`define WB_DAT_W 8

// Register map
`define REG_CTRL   0
`define REG_STATUS 1

// PLL lock-loss watchdog
`define LOCK_HOLD_CYCLES 256
`define LOCK_CNT_W       9

`endif

// File: source/audio_pkg.sv
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

    typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

    // 0 high, 1 very high, 2 very low, 3 low
    typedef logic [1:0] fx_level_t;

    typedef logic [`WB_ADR_W-1:0] wb_adr_t;
    typedef logic [`WB_DAT_W-1:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
    } wb_rsp_t;

    typedef struct packed {
        fx_level_t fx_level;
        logic      stereo;
        logic      mute;
    } audio_cfg_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

endpackage

`default_nettype wire

// File: source/audio_ctrl_regs.sv
`default_nettype none

`include "audio_settings.svh"

module audio_ctrl_regs (
    input  logic                  CLK_AUDIO,
    input  logic                  RESET,
    input  audio_pkg::wb_req_t    wb_req,
    output audio_pkg::wb_rsp_t    wb_rsp,
    input  logic                  pll_locked,
    input  logic                  hold,
    input  logic                  core_rst,
    output audio_pkg::audio_cfg_t cfg,
    output logic                  soft_rst
);

    import audio_pkg::*;

    localparam wb_adr_t CTRL_ADR   = `WB_ADR_W'(`REG_CTRL);
    localparam wb_adr_t STATUS_ADR = `WB_ADR_W'(`REG_STATUS);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } bus_state_t;

    bus_state_t state;
    logic       bus_start;
    logic [4:0] ctrl_q;
    wb_dat_t    status;
    wb_dat_t    rd_dat;

    ////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////

    // New cycle is only accepted from idle
    assign bus_start = wb_req.cyc & wb_req.stb & (state == ST_IDLE);

    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (bus_start) state <= ST_ACK;
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    // CTRL is written on the same edge that raises ack
    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            ctrl_q <= '0;
        end else if (bus_start && wb_req.we && wb_req.adr == CTRL_ADR) begin
            ctrl_q <= wb_req.dat[4:0];
        end
    end

    assign status = {5'b0, core_rst, hold, pll_locked};

    always_ff @(posedge CLK_AUDIO) begin
        if (bus_start) begin
            case (wb_req.adr)
                CTRL_ADR:   rd_dat <= {3'b0, ctrl_q};
                STATUS_ADR: rd_dat <= status;
                default:    rd_dat <= '0;
            endcase
        end
    end

    assign wb_rsp = '{dat: rd_dat, ack: (state == ST_ACK)};

    // Field split of CTRL
    assign soft_rst = ctrl_q[0];
    assign cfg      = '{fx_level: ctrl_q[2:1], stereo: ctrl_q[3], mute: ctrl_q[4]};

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_single_ack: assert property (
        @(posedge CLK_AUDIO) disable iff (RESET)
        wb_rsp.ack |=> !wb_rsp.ack
    );

endmodule

`default_nettype wire

// File: source/pll_lock_watchdog.sv
`default_nettype none

`include "audio_settings.svh"

module pll_lock_watchdog (
    input  logic CLK_AUDIO,
    input  logic RESET,
    input  logic pll_locked,
    input  logic soft_rst,
    input  logic user_button,
    output logic hold,
    output logic core_rst
);

    localparam logic [`LOCK_CNT_W-1:0] HOLD_LAST = `LOCK_CNT_W'(`LOCK_HOLD_CYCLES - 1);

    logic                   last_locked;
    logic                   lock_lost;
    logic [`LOCK_CNT_W-1:0] hold_cnt;

    // Falling edge of lock between two samples
    assign lock_lost = last_locked & ~pll_locked;

    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
        end else begin
            last_locked <= pll_locked;
        end
    end

    // Hold stretch, restarted by any new loss
    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            hold     <= 1'b0;
            hold_cnt <= '0;
        end else if (lock_lost) begin
            hold     <= 1'b1;
            hold_cnt <= HOLD_LAST;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end else begin
            hold <= 1'b0;
        end
    end

    // Combined core reset, held high through board reset
    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            core_rst <= 1'b1;
        end else begin
            core_rst <= hold | ~pll_locked | soft_rst | user_button;
        end
    end

    a_hold_len: assert property (
        @(posedge CLK_AUDIO) disable iff (RESET)
        lock_lost ##1 (!lock_lost)[*`LOCK_HOLD_CYCLES] |=> !hold
    );

    a_hold_rst: assert property (
        @(posedge CLK_AUDIO) disable iff (RESET)
        hold |=> core_rst
    );

endmodule

`default_nettype wire

// File: source/audio_sync.sv
`default_nettype none

module audio_sync (
    input  logic               CLK_AUDIO,
    input  logic               RESET,
    input  audio_pkg::sample_t snd_left,
    input  audio_pkg::sample_t snd_right,
    input  logic               stereo,
    output audio_pkg::stereo_t samples
);

    import audio_pkg::*;

    stereo_t stage1;
    stereo_t stage2;

    ////////////////////////////////////////////////////////////
    // Capture from the game clock domain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            stage1 <= '0;
            stage2 <= '0;
        end else begin
            stage1 <= '{left: snd_left, right: snd_right};
            stage2 <= stage1;
        end
    end

    // Mono games only drive the left channel
    always_comb begin
        samples = stage2;
        if (!stereo) begin
            samples.right = stage2.left;
        end
    end

endmodule

`default_nettype wire

// File: source/audio_level.sv
`default_nettype none

`include "audio_settings.svh"

module audio_level (
    input  logic                 CLK_AUDIO,
    input  logic                 RESET,
    input  audio_pkg::stereo_t   samples,
    input  audio_pkg::fx_level_t fx_level,
    input  logic                 mute,
    output audio_pkg::sample_t   audio_l,
    output audio_pkg::sample_t   audio_r
);

    import audio_pkg::*;

    localparam fx_level_t FX_HIGH      = 2'd0;
    localparam fx_level_t FX_VERY_HIGH = 2'd1;
    localparam fx_level_t FX_VERY_LOW  = 2'd2;
    localparam fx_level_t FX_LOW       = 2'd3;

    localparam sample_t SAMPLE_MAX = {1'b0, {(`AUDIO_SAMPLE_W-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`AUDIO_SAMPLE_W-1){1'b0}}};

    sample_t scaled_l;
    sample_t scaled_r;

    // Gain per volume code
    function automatic sample_t scale(input sample_t s, input fx_level_t lvl);
        logic over;
        over = s[`AUDIO_SAMPLE_W-1] ^ s[`AUDIO_SAMPLE_W-2];
        case (lvl)
            FX_VERY_HIGH: begin
                // Doubling overflows when the two top bits differ
                if (over) begin
                    scale = s[`AUDIO_SAMPLE_W-1] ? SAMPLE_MIN : SAMPLE_MAX;
                end else begin
                    scale = s <<< 1;
                end
            end
            FX_VERY_LOW: scale = s >>> 2;
            FX_LOW:      scale = s >>> 1;
            FX_HIGH:     scale = s;
        endcase
    endfunction

    assign scaled_l = mute ? '0 : scale(samples.left, fx_level);
    assign scaled_r = mute ? '0 : scale(samples.right, fx_level);

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK_AUDIO or posedge RESET) begin
        if (RESET) begin
            audio_l <= '0;
            audio_r <= '0;
        end else begin
            audio_l <= scaled_l;
            audio_r <= scaled_r;
        end
    end

endmodule

`default_nettype wire

// File: source/audio_top.sv
`default_nettype none

module audio_top (
    input  logic               CLK_AUDIO,
    input  logic               RESET,
    input  logic               pll_locked,
    input  logic               user_button,
    input  audio_pkg::wb_req_t wb_req,
    output audio_pkg::wb_rsp_t wb_rsp,
    input  audio_pkg::sample_t snd_left,
    input  audio_pkg::sample_t snd_right,
    output audio_pkg::sample_t audio_l,
    output audio_pkg::sample_t audio_r,
    output logic               core_rst
);

    import audio_pkg::*;

    audio_cfg_t cfg;
    logic       soft_rst;
    logic       hold;
    stereo_t    samples;

    // Control and status registers
    audio_ctrl_regs i_ctrl_regs (
        .CLK_AUDIO  (CLK_AUDIO),
        .RESET      (RESET),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .pll_locked (pll_locked),
        .hold       (hold),
        .core_rst   (core_rst),
        .cfg        (cfg),
        .soft_rst   (soft_rst)
    );

    pll_lock_watchdog i_watchdog (
        .CLK_AUDIO   (CLK_AUDIO),
        .RESET       (RESET),
        .pll_locked  (pll_locked),
        .soft_rst    (soft_rst),
        .user_button (user_button),
        .hold        (hold),
        .core_rst    (core_rst)
    );

    ////////////////////////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////////////////////////

    audio_sync i_sync (
        .CLK_AUDIO (CLK_AUDIO),
        .RESET     (RESET),
        .snd_left  (snd_left),
        .snd_right (snd_right),
        .stereo    (cfg.stereo),
        .samples   (samples)
    );

    audio_level i_level (
        .CLK_AUDIO (CLK_AUDIO),
        .RESET     (RESET),
        .samples   (samples),
        .fx_level  (cfg.fx_level),
        .mute      (cfg.mute),
        .audio_l   (audio_l),
        .audio_r   (audio_r)
    );

endmodule

`default_nettype wire

// File: verification/tb_audio_top.sv
`default_nettype none

`include "audio_settings.svh"

module tb_audio_top;

    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    localparam wb_adr_t CTRL_ADR   = `WB_ADR_W'(`REG_CTRL);
    localparam wb_adr_t STATUS_ADR = `WB_ADR_W'(`REG_STATUS);
    localparam int SMAX = 2 ** (`AUDIO_SAMPLE_W - 1) - 1;
    localparam int SMIN = -(2 ** (`AUDIO_SAMPLE_W - 1));
    localparam int N_ROWS = 12;
    localparam int N_RAND = 8;

    // Row budget plus the watchdog test with a threefold margin
    localparam int ROW_CYCLES     = 20;
    localparam int WD_CYCLES      = `LOCK_HOLD_CYCLES + 44;
    localparam int TIMEOUT_CYCLES = 3 * ((N_ROWS + N_RAND) * ROW_CYCLES + WD_CYCLES);

    typedef struct {
        string     name;
        fx_level_t fx_level;
        logic      stereo;
        logic      mute;
        sample_t   left;
        sample_t   right;
        sample_t   exp_l;
        sample_t   exp_r;
    } row_t;

    // name, fx_level, stereo, mute, left, right, expected audio_l, expected audio_r
    row_t rows [N_ROWS] = '{
        '{"high",      2'd0, 1'b1, 1'b0, 16'sd1000, -16'sd2000, 16'sd1000, -16'sd2000},
        '{"very_high", 2'd1, 1'b1, 1'b0, 16'sd1000, -16'sd1000, 16'sd2000, -16'sd2000},
        '{"sat_pos",   2'd1, 1'b1, 1'b0, 16'sd20000, 16'sd16384, 16'sh7fff, 16'sh7fff},
        '{"sat_neg",   2'd1, 1'b1, 1'b0, -16'sd20000, -16'sd16384, 16'sh8000, 16'sh8000},
        '{"very_low",  2'd2, 1'b1, 1'b0, 16'sd1001, -16'sd1001, 16'sd250, -16'sd251},
        '{"low",       2'd3, 1'b1, 1'b0, 16'sd1001, -16'sd1001, 16'sd500, -16'sd501},
        '{"low_ends",  2'd3, 1'b1, 1'b0, 16'sh7fff, 16'sh8000, 16'sd16383, -16'sd16384},
        '{"vlow_odd",  2'd2, 1'b1, 1'b0, -16'sd1, 16'sd3, -16'sd1, 16'sd0},
        '{"mono_high", 2'd0, 1'b0, 1'b0, 16'sd1234, -16'sd999, 16'sd1234, 16'sd1234},
        '{"mono_sat",  2'd1, 1'b0, 1'b0, -16'sd30000, 16'sd5, 16'sh8000, 16'sh8000},
        '{"mute_st",   2'd0, 1'b1, 1'b1, 16'sd1234, -16'sd999, 16'sd0, 16'sd0},
        '{"mute_mono", 2'd1, 1'b0, 1'b1, 16'sh7fff, 16'sh8000, 16'sd0, 16'sd0}
    };

    logic    CLK_AUDIO;
    logic    RESET;
    logic    pll_locked;
    logic    user_button;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    sample_t snd_left;
    sample_t snd_right;
    sample_t audio_l;
    sample_t audio_r;
    logic    core_rst;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int seed   = 32'h1348_0cde;

    audio_top i_dut (
        .CLK_AUDIO   (CLK_AUDIO),
        .RESET       (RESET),
        .pll_locked  (pll_locked),
        .user_button (user_button),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .snd_left    (snd_left),
        .snd_right   (snd_right),
        .audio_l     (audio_l),
        .audio_r     (audio_r),
        .core_rst    (core_rst)
    );

    initial CLK_AUDIO = 1'b0;
    always #50 CLK_AUDIO = ~CLK_AUDIO;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic expect_eq(input string name, input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // One Wishbone classic cycle with the request held until ack
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                             output wb_dat_t rdat);
        int waited;
        waited = 1;
        rdat = '0;
        @(negedge CLK_AUDIO);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge CLK_AUDIO);
        while (!wb_rsp.ack && waited < 4) begin
            @(negedge CLK_AUDIO);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            errors++;
            $display("Bus %s at address %0d got no ack within 4 cycles",
                     we ? "write" : "read", adr);
        end
        wb_req = '0;
    endtask

    // Volume gain by code with clipping to the sample range
    function automatic int expected_level(input int s, input int code);
        int v;
        case (code)
            1:       v = 2 * s;
            2:       v = s >>> 2;
            3:       v = s >>> 1;
            default: v = s;
        endcase
        if (v > SMAX) v = SMAX;
        if (v < SMIN) v = SMIN;
        return v;
    endfunction

    task automatic apply_row(input string name, input fx_level_t fx, input logic st,
                             input logic mt, input sample_t l, input sample_t r,
                             input sample_t exp_l, input sample_t exp_r);
        wb_dat_t rd;
        @(negedge CLK_AUDIO);
        snd_left  = l;
        snd_right = r;
        bus_cycle(1'b1, CTRL_ADR, {3'b0, mt, st, fx, 1'b0}, rd);
        // Output follows the new CTRL within 2 cycles of ack
        repeat (2) @(negedge CLK_AUDIO);
        expect_eq({name, " audio_l"}, 32'(exp_l), 32'(audio_l));
        expect_eq({name, " audio_r"}, 32'(exp_r), 32'(audio_r));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        wb_dat_t   rd;
        fx_level_t fx;
        logic      st;
        sample_t   l;
        sample_t   r;
        sample_t   el;
        sample_t   er;
        int        rnd;
        int        t0;
        RESET       = 1'b1;
        pll_locked  = 1'b1;
        user_button = 1'b0;
        wb_req      = '0;
        snd_left    = '0;
        snd_right   = '0;
        repeat (2) @(negedge CLK_AUDIO);
        expect_eq("core_rst in reset", 1, 32'(core_rst));
        RESET = 1'b0;
        repeat (2) @(negedge CLK_AUDIO);
        expect_eq("core_rst after reset", 0, 32'(core_rst));
        bus_cycle(1'b0, CTRL_ADR, '0, rd);
        expect_eq("CTRL after reset", 0, 32'(rd));
        bus_cycle(1'b0, STATUS_ADR, '0, rd);
        expect_eq("STATUS after reset", 1, 32'(rd));

        // Register access with soft reset raised through CTRL bit 0
        bus_cycle(1'b1, CTRL_ADR, 8'hff, rd);
        @(negedge CLK_AUDIO);
        expect_eq("core_rst on soft reset", 1, 32'(core_rst));
        bus_cycle(1'b0, CTRL_ADR, '0, rd);
        expect_eq("CTRL readback", 32'h1f, 32'(rd));
        bus_cycle(1'b0, STATUS_ADR, '0, rd);
        expect_eq("STATUS in soft reset", 32'h05, 32'(rd));
        bus_cycle(1'b1, STATUS_ADR, 8'hff, rd);
        bus_cycle(1'b0, STATUS_ADR, '0, rd);
        expect_eq("STATUS after write", 32'h05, 32'(rd));
        bus_cycle(1'b1, CTRL_ADR, 8'h00, rd);
        @(negedge CLK_AUDIO);
        expect_eq("core_rst soft reset off", 0, 32'(core_rst));

        // User button
        user_button = 1'b1;
        repeat (2) @(negedge CLK_AUDIO);
        expect_eq("core_rst on button", 1, 32'(core_rst));
        user_button = 1'b0;
        repeat (2) @(negedge CLK_AUDIO);
        expect_eq("core_rst button off", 0, 32'(core_rst));

        foreach (rows[i]) begin
            apply_row(rows[i].name, rows[i].fx_level, rows[i].stereo, rows[i].mute,
                      rows[i].left, rows[i].right, rows[i].exp_l, rows[i].exp_r);
        end

        for (int k = 0; k < N_RAND; k++) begin
            rnd = $random(seed);
            fx  = rnd[1:0];
            st  = rnd[2];
            rnd = $random(seed);
            l   = rnd[`AUDIO_SAMPLE_W-1:0];
            rnd = $random(seed);
            r   = rnd[`AUDIO_SAMPLE_W-1:0];
            el  = sample_t'(expected_level(int'(l), int'(fx)));
            er  = st ? sample_t'(expected_level(int'(r), int'(fx))) : el;
            apply_row($sformatf("random %0d", k), fx, st, 1'b0, l, r, el, er);
        end

        // One-cycle lock loss
        @(negedge CLK_AUDIO);
        pll_locked = 1'b0;
        t0 = cycles;
        @(negedge CLK_AUDIO);
        pll_locked = 1'b1;
        bus_cycle(1'b0, STATUS_ADR, '0, rd);
        expect_eq("STATUS during hold", 32'h07, 32'(rd));
        while (core_rst && cycles - t0 <= `LOCK_HOLD_CYCLES + 3) begin
            @(negedge CLK_AUDIO);
        end
        checks++;
        if (core_rst) begin
            errors++;
            $display("core_rst still high %0d cycles after the lock loss", cycles - t0);
        end else if (cycles - t0 < `LOCK_HOLD_CYCLES) begin
            errors++;
            $display("core_rst cleared after %0d cycles, before the hold ended", cycles - t0);
        end
        bus_cycle(1'b0, STATUS_ADR, '0, rd);
        expect_eq("STATUS after hold", 32'h01, 32'(rd));

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK_AUDIO);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/audio_pkg.sv
source/audio_ctrl_regs.sv
source/pll_lock_watchdog.sv
source/audio_sync.sv
source/audio_level.sv
source/audio_top.sv
verification/tb_audio_top.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_audio_top
RTL_TOP   ?= audio_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
